//--- all.f
+incdir+tests
rtl/cp0_pkg.sv
rtl/seg_map.sv
rtl/tlb_lookup.sv
rtl/tlb_array.sv
rtl/addr_xlate.sv
rtl/cp0_regs.sv
rtl/cp0_top.sv
tests/tb_cp0_top.sv

//--- rtl/addr_xlate.sv
`timescale 1ns/1ns

module addr_xlate #(
    parameter int NUM_ENTRIES = 4
) (
    input  logic [31:0]                           va_i,
    input  logic                                  store_i,
    input  cp0_pkg::tlb_entry_t [NUM_ENTRIES-1:0] entries_i,
    input  logic [7:0]                            asid_i,
    input  logic                                  user_mode_i,
    input  logic                                  k0_uncached_i,
    input  logic                                  cache_off_i,
    output cp0_pkg::xlate_res_t                   res_o
);
    import cp0_pkg::*;

    logic        mapped;
    logic [31:0] direct_pa;
    logic        seg_uncached;
    logic        illegal;
    lookup_res_t tlb_res;

    seg_map u_seg_map (
        .va_i          (va_i),
        .user_mode_i   (user_mode_i),
        .k0_uncached_i (k0_uncached_i),
        .mapped_o      (mapped),
        .direct_pa_o   (direct_pa),
        .seg_uncached_o(seg_uncached),
        .illegal_o     (illegal)
    );

    tlb_lookup #(
        .NUM_ENTRIES(NUM_ENTRIES)
    ) u_tlb_lookup (
        .entries_i(entries_i),
        .va_i     (va_i),
        .asid_i   (asid_i),
        .res_o    (tlb_res)
    );

    assign res_o.pa       = mapped ? {tlb_res.pfn, va_i[11:0]} : direct_pa;
    assign res_o.miss     = mapped & ~tlb_res.hit;
    assign res_o.invalid  = mapped & tlb_res.hit & ~tlb_res.v;
    // store to a clean page
    assign res_o.dirty    = mapped & tlb_res.hit & store_i & ~tlb_res.d;
    assign res_o.uncached = seg_uncached | cache_off_i |
                            (mapped & tlb_res.hit & (tlb_res.c == CACHE_UNCACHED));
    assign res_o.illegal  = illegal;

endmodule

//--- rtl/cp0_pkg.sv
package cp0_pkg;

    typedef logic [4:0] cp0_addr_t;

    // register numbers
    localparam cp0_addr_t CP0_INDEX    = 5'd0;
    localparam cp0_addr_t CP0_ENTRYLO0 = 5'd2;
    localparam cp0_addr_t CP0_ENTRYLO1 = 5'd3;
    localparam cp0_addr_t CP0_PAGEMASK = 5'd5;
    localparam cp0_addr_t CP0_BADVADDR = 5'd8;
    localparam cp0_addr_t CP0_COUNT    = 5'd9;
    localparam cp0_addr_t CP0_ENTRYHI  = 5'd10;
    localparam cp0_addr_t CP0_COMPARE  = 5'd11;
    localparam cp0_addr_t CP0_STATUS   = 5'd12;
    localparam cp0_addr_t CP0_CAUSE    = 5'd13;
    localparam cp0_addr_t CP0_EPC      = 5'd14;
    localparam cp0_addr_t CP0_CONFIG   = 5'd16;
    localparam cp0_addr_t CP0_CACHEOFF = 5'd22;

    // reset values, BEV set in status
    localparam logic [31:0] STATUS_RESET = 32'h0040_0000;
    localparam logic [31:0] PAGEMASK_4K  = 32'h0000_0000;
    localparam logic [31:0] CONFIG_RESET = 32'h0000_0003;

    // software writable bits
    localparam logic [31:0] STATUS_WMASK  = 32'h0000_ff13;
    localparam logic [31:0] ENTRYHI_WMASK = 32'hffff_e0ff;
    localparam logic [31:0] ENTRYLO_WMASK = 32'h03ff_ffff;

    // status field positions
    localparam int STATUS_IE  = 0;
    localparam int STATUS_EXL = 1;
    localparam int STATUS_UM  = 4;

    // cache attribute meaning uncached, for Config.K0 and TLB C
    localparam logic [2:0] CACHE_UNCACHED = 3'd2;

    typedef struct packed {
        logic [18:0] vpn2;
        logic [7:0]  asid;
        logic        g;
        logic [19:0] pfn0;
        logic [2:0]  c0;
        logic        d0;
        logic        v0;
        logic [19:0] pfn1;
        logic [2:0]  c1;
        logic        d1;
        logic        v1;
    } tlb_entry_t;

    typedef struct packed {
        logic        bd;
        logic [4:0]  code;
        logic [31:0] epc;
        logic [31:0] badvaddr;
        logic        badvaddr_we;
    } exc_info_t;

    typedef struct packed {
        logic        hit;
        logic [7:0]  idx;
        logic [19:0] pfn;
        logic [2:0]  c;
        logic        d;
        logic        v;
    } lookup_res_t;

    typedef struct packed {
        logic [31:0] pa;
        logic        uncached;
        logic        miss;
        logic        invalid;
        logic        dirty;
        logic        illegal;
    } xlate_res_t;

endpackage

//--- rtl/cp0_regs.sv
`timescale 1ns/1ns

module cp0_regs #(
    parameter int NUM_ENTRIES = 4,
    localparam int IDX_W = $clog2(NUM_ENTRIES)
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 we_i,
    input  cp0_pkg::cp0_addr_t   waddr_i,
    input  logic [31:0]          wdata_i,
    input  cp0_pkg::cp0_addr_t   raddr_i,
    input  logic [5:0]           hw_int_i,
    input  logic                 exc_valid_i,
    input  cp0_pkg::exc_info_t   exc_i,
    input  logic                 eret_i,
    input  logic                 tlbr_i,
    input  logic                 tlbp_i,
    input  cp0_pkg::tlb_entry_t  rd_entry_i,
    input  cp0_pkg::lookup_res_t probe_i,
    output logic [31:0]          rdata_o,
    output logic [31:0]          epc_o,
    output logic [7:0]           int_pending_o,
    output logic                 allow_int_o,
    output cp0_pkg::tlb_entry_t  stage_entry_o,
    output logic [IDX_W-1:0]     tlb_index_o,
    output logic [7:0]           cur_asid_o,
    output logic [31:0]          probe_va_o,
    output logic                 user_mode_o,
    output logic                 k0_uncached_o,
    output logic                 cache_off_o
);
    import cp0_pkg::*;

    logic             index_p;
    logic [IDX_W-1:0] index_idx;
    logic [31:0]      entrylo0_q;
    logic [31:0]      entrylo1_q;
    logic [31:0]      badvaddr_q;
    logic [31:0]      count_q;
    logic             count_tick;
    logic [31:0]      entryhi_q;
    logic [31:0]      compare_q;
    logic [31:0]      status_q;
    logic             cause_bd;
    logic             cause_ti;
    logic [1:0]       cause_ip_sw;
    logic [4:0]       cause_code;
    logic [31:0]      epc_q;
    logic [31:0]      config_q;
    logic             cache_off_q;
    logic [7:0]       ip_live;

    // timer shares IP7 with the top hardware line
    assign ip_live = {hw_int_i[5] | cause_ti, hw_int_i[4:0], cause_ip_sw};

    always_ff @(posedge clk) begin
        if (rst) begin
            index_p     <= 1'b0;
            index_idx   <= '0;
            entrylo0_q  <= '0;
            entrylo1_q  <= '0;
            badvaddr_q  <= '0;
            count_q     <= '0;
            count_tick  <= 1'b0;
            entryhi_q   <= '0;
            compare_q   <= '0;
            status_q    <= STATUS_RESET;
            cause_bd    <= 1'b0;
            cause_ti    <= 1'b0;
            cause_ip_sw <= '0;
            cause_code  <= '0;
            epc_q       <= '0;
            config_q    <= CONFIG_RESET;
            cache_off_q <= 1'b0;
        end else begin
            // count runs at half the clock rate
            count_tick <= ~count_tick;
            count_q    <= count_q + {31'd0, count_tick};
            if (count_q == compare_q) begin
                cause_ti <= 1'b1;
            end

            if (we_i) begin
                case (waddr_i)
                    CP0_INDEX:    index_idx   <= wdata_i[IDX_W-1:0];
                    CP0_ENTRYLO0: entrylo0_q  <= wdata_i & ENTRYLO_WMASK;
                    CP0_ENTRYLO1: entrylo1_q  <= wdata_i & ENTRYLO_WMASK;
                    CP0_COUNT:    count_q     <= wdata_i;
                    CP0_ENTRYHI:  entryhi_q   <= wdata_i & ENTRYHI_WMASK;
                    CP0_COMPARE: begin
                        compare_q <= wdata_i;
                        cause_ti  <= 1'b0;
                    end
                    CP0_STATUS: begin
                        status_q <= (status_q & ~STATUS_WMASK) | (wdata_i & STATUS_WMASK);
                    end
                    CP0_CAUSE:    cause_ip_sw <= wdata_i[9:8];
                    CP0_EPC:      epc_q       <= wdata_i;
                    CP0_CONFIG:   config_q[2:0] <= wdata_i[2:0];
                    CP0_CACHEOFF: cache_off_q <= wdata_i[0];
                    default: ;
                endcase
            end

            // index keeps its old value on a probe miss
            if (tlbp_i) begin
                index_p <= ~probe_i.hit;
                if (probe_i.hit) begin
                    index_idx <= probe_i.idx[IDX_W-1:0];
                end
            end

            if (tlbr_i) begin
                entryhi_q  <= {rd_entry_i.vpn2, 5'b0, rd_entry_i.asid};
                entrylo0_q <= {6'b0, rd_entry_i.pfn0, rd_entry_i.c0, rd_entry_i.d0,
                               rd_entry_i.v0, rd_entry_i.g};
                entrylo1_q <= {6'b0, rd_entry_i.pfn1, rd_entry_i.c1, rd_entry_i.d1,
                               rd_entry_i.v1, rd_entry_i.g};
            end

            // exception overrides software writes and tlbr
            if (exc_valid_i) begin
                epc_q                <= exc_i.epc;
                cause_bd             <= exc_i.bd;
                cause_code           <= exc_i.code;
                status_q[STATUS_EXL] <= 1'b1;
                if (exc_i.badvaddr_we) begin
                    badvaddr_q       <= exc_i.badvaddr;
                    entryhi_q[31:13] <= exc_i.badvaddr[31:13];
                end
            end

            if (eret_i) begin
                status_q[STATUS_EXL] <= 1'b0;
            end
        end
    end

    always_comb begin
        case (raddr_i)
            CP0_INDEX:    rdata_o = {index_p, {(31 - IDX_W){1'b0}}, index_idx};
            CP0_ENTRYLO0: rdata_o = entrylo0_q;
            CP0_ENTRYLO1: rdata_o = entrylo1_q;
            CP0_PAGEMASK: rdata_o = PAGEMASK_4K;
            CP0_BADVADDR: rdata_o = badvaddr_q;
            CP0_COUNT:    rdata_o = count_q;
            CP0_ENTRYHI:  rdata_o = entryhi_q;
            CP0_COMPARE:  rdata_o = compare_q;
            CP0_STATUS:   rdata_o = status_q;
            CP0_CAUSE:    rdata_o = {cause_bd, cause_ti, 14'b0, ip_live, 1'b0, cause_code, 2'b0};
            CP0_EPC:      rdata_o = epc_q;
            CP0_CONFIG:   rdata_o = config_q;
            CP0_CACHEOFF: rdata_o = {31'b0, cache_off_q};
            default:      rdata_o = '0;
        endcase
    end

    assign epc_o         = epc_q;
    assign int_pending_o = status_q[15:8] & ip_live;
    assign allow_int_o   = status_q[STATUS_IE] & ~status_q[STATUS_EXL] & ~exc_valid_i;

    // global bit is the AND of both halves
    assign stage_entry_o = '{
        vpn2: entryhi_q[31:13],
        asid: entryhi_q[7:0],
        g:    entrylo0_q[0] & entrylo1_q[0],
        pfn0: entrylo0_q[25:6],
        c0:   entrylo0_q[5:3],
        d0:   entrylo0_q[2],
        v0:   entrylo0_q[1],
        pfn1: entrylo1_q[25:6],
        c1:   entrylo1_q[5:3],
        d1:   entrylo1_q[2],
        v1:   entrylo1_q[1]
    };

    assign tlb_index_o   = index_idx;
    assign cur_asid_o    = entryhi_q[7:0];
    assign probe_va_o    = {entryhi_q[31:13], 13'b0};
    assign user_mode_o   = status_q[STATUS_UM] & ~status_q[STATUS_EXL];
    assign k0_uncached_o = (config_q[2:0] == CACHE_UNCACHED);
    assign cache_off_o   = cache_off_q;

endmodule

//--- rtl/cp0_top.sv
`timescale 1ns/1ns

module cp0_top #(
    parameter int NUM_ENTRIES = 4,
    localparam int IDX_W = $clog2(NUM_ENTRIES)
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                cp0_we_i,
    input  cp0_pkg::cp0_addr_t  cp0_waddr_i,
    input  logic [31:0]         cp0_wdata_i,
    input  cp0_pkg::cp0_addr_t  cp0_raddr_i,
    input  logic [5:0]          hw_int_i,
    input  logic                exc_valid_i,
    input  cp0_pkg::exc_info_t  exc_i,
    input  logic                eret_i,
    input  logic                tlbwi_i,
    input  logic                tlbr_i,
    input  logic                tlbp_i,
    input  logic [31:0]         inst_va_i,
    input  logic [31:0]         data_va_i,
    input  logic                data_store_i,
    output logic [31:0]         cp0_rdata_o,
    output logic [31:0]         epc_o,
    output logic [7:0]          int_pending_o,
    output logic                allow_int_o,
    output cp0_pkg::xlate_res_t inst_res_o,
    output cp0_pkg::xlate_res_t data_res_o
);
    import cp0_pkg::*;

    tlb_entry_t                   stage_entry;
    tlb_entry_t                   rd_entry;
    tlb_entry_t [NUM_ENTRIES-1:0] entries;
    lookup_res_t                  probe_res;
    logic [IDX_W-1:0]             tlb_index;
    logic [7:0]                   cur_asid;
    logic [31:0]                  probe_va;
    logic                         user_mode;
    logic                         k0_uncached;
    logic                         cache_off;

    cp0_regs #(
        .NUM_ENTRIES(NUM_ENTRIES)
    ) u_cp0_regs (
        .clk          (clk),
        .rst          (rst),
        .we_i         (cp0_we_i),
        .waddr_i      (cp0_waddr_i),
        .wdata_i      (cp0_wdata_i),
        .raddr_i      (cp0_raddr_i),
        .hw_int_i     (hw_int_i),
        .exc_valid_i  (exc_valid_i),
        .exc_i        (exc_i),
        .eret_i       (eret_i),
        .tlbr_i       (tlbr_i),
        .tlbp_i       (tlbp_i),
        .rd_entry_i   (rd_entry),
        .probe_i      (probe_res),
        .rdata_o      (cp0_rdata_o),
        .epc_o        (epc_o),
        .int_pending_o(int_pending_o),
        .allow_int_o  (allow_int_o),
        .stage_entry_o(stage_entry),
        .tlb_index_o  (tlb_index),
        .cur_asid_o   (cur_asid),
        .probe_va_o   (probe_va),
        .user_mode_o  (user_mode),
        .k0_uncached_o(k0_uncached),
        .cache_off_o  (cache_off)
    );

    tlb_array #(
        .NUM_ENTRIES(NUM_ENTRIES)
    ) u_tlb_array (
        .clk       (clk),
        .rst       (rst),
        .tlbwi_i   (tlbwi_i),
        .index_i   (tlb_index),
        .wr_entry_i(stage_entry),
        .entries_o (entries),
        .rd_entry_o(rd_entry)
    );

    // probe looks up the EntryHi VPN2 and ASID
    tlb_lookup #(
        .NUM_ENTRIES(NUM_ENTRIES)
    ) u_probe (
        .entries_i(entries),
        .va_i     (probe_va),
        .asid_i   (cur_asid),
        .res_o    (probe_res)
    );

    // fetch never stores
    addr_xlate #(
        .NUM_ENTRIES(NUM_ENTRIES)
    ) u_inst_xlate (
        .va_i         (inst_va_i),
        .store_i      (1'b0),
        .entries_i    (entries),
        .asid_i       (cur_asid),
        .user_mode_i  (user_mode),
        .k0_uncached_i(k0_uncached),
        .cache_off_i  (cache_off),
        .res_o        (inst_res_o)
    );

    addr_xlate #(
        .NUM_ENTRIES(NUM_ENTRIES)
    ) u_data_xlate (
        .va_i         (data_va_i),
        .store_i      (data_store_i),
        .entries_i    (entries),
        .asid_i       (cur_asid),
        .user_mode_i  (user_mode),
        .k0_uncached_i(k0_uncached),
        .cache_off_i  (cache_off),
        .res_o        (data_res_o)
    );

endmodule

//--- rtl/seg_map.sv
`timescale 1ns/1ns

module seg_map (
    input  logic [31:0] va_i,
    input  logic        user_mode_i,
    input  logic        k0_uncached_i,
    output logic        mapped_o,
    output logic [31:0] direct_pa_o,
    output logic        seg_uncached_o,
    output logic        illegal_o
);

    logic is_kseg0;
    logic is_kseg1;

    // kseg0 at 0x8000_0000, kseg1 at 0xa000_0000
    assign is_kseg0 = (va_i[31:29] == 3'b100);
    assign is_kseg1 = (va_i[31:29] == 3'b101);

    assign mapped_o       = ~(is_kseg0 | is_kseg1);
    assign direct_pa_o    = {3'b000, va_i[28:0]};
    assign seg_uncached_o = is_kseg1 | (is_kseg0 & k0_uncached_i);

    // upper half is kernel only
    assign illegal_o = user_mode_i & va_i[31];

endmodule

//--- rtl/tlb_array.sv
`timescale 1ns/1ns

module tlb_array #(
    parameter int NUM_ENTRIES = 4,
    localparam int IDX_W = $clog2(NUM_ENTRIES)
) (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  tlbwi_i,
    input  logic [IDX_W-1:0]                      index_i,
    input  cp0_pkg::tlb_entry_t                   wr_entry_i,
    output cp0_pkg::tlb_entry_t [NUM_ENTRIES-1:0] entries_o,
    output cp0_pkg::tlb_entry_t                   rd_entry_o
);
    import cp0_pkg::*;

    tlb_entry_t [NUM_ENTRIES-1:0] entries_q;

    // cleared entries have v0 and v1 low, so nothing translates after reset
    always_ff @(posedge clk) begin
        if (rst) begin
            entries_q <= '0;
        end else if (tlbwi_i) begin
            entries_q[index_i] <= wr_entry_i;
        end
    end

    assign entries_o  = entries_q;
    assign rd_entry_o = entries_q[index_i];

endmodule

//--- rtl/tlb_lookup.sv
`timescale 1ns/1ns

module tlb_lookup #(
    parameter int NUM_ENTRIES = 4
) (
    input  cp0_pkg::tlb_entry_t [NUM_ENTRIES-1:0] entries_i,
    input  logic [31:0]                           va_i,
    input  logic [7:0]                            asid_i,
    output cp0_pkg::lookup_res_t                  res_o
);
    import cp0_pkg::*;

    logic [NUM_ENTRIES-1:0] match;

    always_comb begin
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            match[i] = (entries_i[i].vpn2 == va_i[31:13]) &&
                       ((entries_i[i].asid == asid_i) || entries_i[i].g);
        end
    end

    // scan downwards so the lowest matching index is left in res_o
    always_comb begin
        res_o = '0;
        for (int i = NUM_ENTRIES - 1; i >= 0; i--) begin
            if (match[i]) begin
                res_o.hit = 1'b1;
                res_o.idx = 8'(i);
                if (va_i[12]) begin
                    res_o.pfn = entries_i[i].pfn1;
                    res_o.c   = entries_i[i].c1;
                    res_o.d   = entries_i[i].d1;
                    res_o.v   = entries_i[i].v1;
                end else begin
                    res_o.pfn = entries_i[i].pfn0;
                    res_o.c   = entries_i[i].c0;
                    res_o.d   = entries_i[i].d0;
                    res_o.v   = entries_i[i].v0;
                end
            end
        end
    end

endmodule

//--- tests/tb_cp0_util.svh
`ifndef TB_CP0_UTIL_SVH
`define TB_CP0_UTIL_SVH

// galois lfsr with taps 32 22 2 1, stepped once per bit taken
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int k = 0; k < n; k++) begin
        r = {r[30:0], lfsr_state[0]};
        if (lfsr_state[0]) begin
            lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
        end else begin
            lfsr_state = lfsr_state >> 1;
        end
    end
    return r;
endfunction

// only IM, UM, EXL and IE take a software write
function automatic logic [31:0] status_model(input logic [31:0] old, input logic [31:0] wd);
    logic [31:0] wmask;
    wmask = 32'h0000_ff13;
    return (old & ~wmask) | (wd & wmask);
endfunction

// BD, TI, IP7..2 from the pins with the timer on IP7, IP1..0, ExcCode
function automatic logic [31:0] cause_model(input logic bd, input logic ti,
                                            input logic [5:0] hw, input logic [1:0] ip_sw,
                                            input logic [4:0] code);
    return {bd, ti, 14'b0, hw[5] | ti, hw[4:0], ip_sw, 1'b0, code, 2'b00};
endfunction

function automatic xlate_res_t xlate_model(input logic [31:0] va, input logic store);
    xlate_res_t  r;
    logic [31:0] lo;
    logic        found;
    r = '0;
    lo = '0;
    found = 1'b0;
    r.illegal = user_mode_m & va[31];
    if (va[31:30] == 2'b10) begin
        r.pa = {3'b000, va[28:0]};
        r.uncached = va[29] | k0_uncached_m;
    end else begin
        // lowest matching entry wins
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if (!found && m_vpn2[i] == va[31:13] && (m_asid[i] == cur_asid_m || m_g[i])) begin
                found = 1'b1;
                lo = va[12] ? m_lo1[i] : m_lo0[i];
            end
        end
        r.pa = {lo[25:6], va[11:0]};
        r.miss = ~found;
        r.invalid = found & ~lo[1];
        r.dirty = found & store & ~lo[2];
        r.uncached = found & (lo[5:3] == 3'd2);
    end
    r.uncached = r.uncached | cache_off_m;
    return r;
endfunction

task automatic wait_timer_irq(input int max_cycles);
    logic [31:0] c;
    int          n;
    c = '0;
    n = 0;
    while (!c[30]) begin
        if (n == max_cycles) begin
            $display("timeout while waiting for Cause.TI to set");
            fail_now();
        end
        read_reg(CP0_CAUSE, c);
        n++;
    end
endtask

`endif

//--- tests/tb_cp0_top.sv
`timescale 1ns/1ns

module tb_cp0_top;
    import cp0_pkg::*;

    localparam int NUM_ENTRIES = 4;
    localparam int IDX_W = $clog2(NUM_ENTRIES);
    localparam logic [3:0] S_ERET  = 4'b1000;
    localparam logic [3:0] S_TLBWI = 4'b0100;
    localparam logic [3:0] S_TLBR  = 4'b0010;
    localparam logic [3:0] S_TLBP  = 4'b0001;

    logic        clk;
    logic        rst;
    logic        cp0_we;
    cp0_addr_t   cp0_waddr;
    logic [31:0] cp0_wdata;
    cp0_addr_t   cp0_raddr;
    logic [5:0]  hw_int;
    logic        exc_valid;
    exc_info_t   exc_in;
    logic        eret;
    logic        tlbwi;
    logic        tlbr;
    logic        tlbp;
    logic [31:0] inst_va;
    logic [31:0] data_va;
    logic        data_store;
    logic [31:0] cp0_rdata;
    logic [31:0] epc;
    logic [7:0]  int_pending;
    logic        allow_int;
    xlate_res_t  inst_res;
    xlate_res_t  data_res;

    // reference state for the models
    logic [31:0] lfsr_state;
    logic [18:0] m_vpn2 [NUM_ENTRIES];
    logic [7:0]  m_asid [NUM_ENTRIES];
    logic        m_g    [NUM_ENTRIES];
    logic [31:0] m_lo0  [NUM_ENTRIES];
    logic [31:0] m_lo1  [NUM_ENTRIES];
    logic [7:0]  cur_asid_m;
    logic        user_mode_m;
    logic        k0_uncached_m;
    logic        cache_off_m;

    logic [31:0] rd;
    logic [31:0] wd;
    logic [31:0] c0;
    logic [31:0] c1;
    logic [1:0]  ip_sw;
    exc_info_t   rec;

    cp0_top #(
        .NUM_ENTRIES(NUM_ENTRIES)
    ) u_cp0_top (
        .clk          (clk),
        .rst          (rst),
        .cp0_we_i     (cp0_we),
        .cp0_waddr_i  (cp0_waddr),
        .cp0_wdata_i  (cp0_wdata),
        .cp0_raddr_i  (cp0_raddr),
        .hw_int_i     (hw_int),
        .exc_valid_i  (exc_valid),
        .exc_i        (exc_in),
        .eret_i       (eret),
        .tlbwi_i      (tlbwi),
        .tlbr_i       (tlbr),
        .tlbp_i       (tlbp),
        .inst_va_i    (inst_va),
        .data_va_i    (data_va),
        .data_store_i (data_store),
        .cp0_rdata_o  (cp0_rdata),
        .epc_o        (epc),
        .int_pending_o(int_pending),
        .allow_int_o  (allow_int),
        .inst_res_o   (inst_res),
        .data_res_o   (data_res)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic fail_now();
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
        assert (got === exp) else begin
            $display("Error: %s is %h, expected %h", name, got, exp);
            fail_now();
        end
    endtask

    task automatic write_reg(input cp0_addr_t a, input logic [31:0] d);
        @(negedge clk);
        cp0_we = 1'b1;
        cp0_waddr = a;
        cp0_wdata = d;
        @(negedge clk);
        cp0_we = 1'b0;
    endtask

    // read mid low phase well away from both edges
    task automatic read_reg(input cp0_addr_t a, output logic [31:0] d);
        @(negedge clk);
        cp0_raddr = a;
        #2;
        d = cp0_rdata;
    endtask

    task automatic pulse_strobe(input logic [3:0] s);
        @(negedge clk);
        {eret, tlbwi, tlbr, tlbp} = s;
        @(negedge clk);
        {eret, tlbwi, tlbr, tlbp} = 4'b0000;
    endtask

    task automatic check_xlate(input logic [31:0] iva, input logic [31:0] dva, input logic st);
        @(negedge clk);
        inst_va = iva;
        data_va = dva;
        data_store = st;
        #2;
        check_val("inst_res_o", inst_res, xlate_model(iva, 1'b0));
        check_val("data_res_o", data_res, xlate_model(dva, st));
    endtask

    `include "tb_cp0_util.svh"

    // mix of random, TLB hit and kseg0/kseg1 addresses
    function automatic logic [31:0] pick_va();
        int i;
        case (rand_bits(2))
            2'd0: return rand_bits(32);
            2'd3: return {2'b10, 30'(rand_bits(30))};
            default: begin
                i = int'(rand_bits(IDX_W));
                return {m_vpn2[i], 13'(rand_bits(13))};
            end
        endcase
    endfunction

    task automatic xlate_round(input int count);
        for (int n = 0; n < count; n++) begin
            check_xlate(pick_va(), pick_va(), 1'(rand_bits(1)));
        end
    endtask

    initial begin
        lfsr_state = 32'h7d15;
        rst = 1'b1;
        cp0_we = 1'b0;
        cp0_waddr = '0;
        cp0_wdata = '0;
        cp0_raddr = '0;
        hw_int = '0;
        exc_valid = 1'b0;
        exc_in = '0;
        {eret, tlbwi, tlbr, tlbp} = 4'b0000;
        inst_va = '0;
        data_va = '0;
        data_store = 1'b0;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            m_vpn2[i] = '0;
            m_asid[i] = '0;
            m_g[i] = 1'b0;
            m_lo0[i] = '0;
            m_lo1[i] = '0;
        end
        cur_asid_m = '0;
        user_mode_m = 1'b0;
        k0_uncached_m = 1'b0;
        cache_off_m = 1'b0;
        repeat (16) @(negedge clk);
        rst = 1'b0;

        // state after reset with all entries zero and invalid
        read_reg(CP0_STATUS, rd);
        check_val("Status", rd, 32'h0040_0000);
        read_reg(CP0_PAGEMASK, rd);
        check_val("PageMask", rd, 32'h0);
        check_val("int_pending_o", int_pending, 8'h0);
        check_val("allow_int_o", allow_int, 1'b0);
        check_xlate(32'h0000_0000, 32'h0040_3000, 1'b1);

        // register access through the masks
        wd = rand_bits(32);
        write_reg(CP0_EPC, wd);
        read_reg(CP0_EPC, rd);
        check_val("EPC", rd, wd);
        wd = rand_bits(32) | 32'h8000_0000;
        write_reg(CP0_COMPARE, wd);
        read_reg(CP0_COMPARE, rd);
        check_val("Compare", rd, wd);
        wd = rand_bits(32);
        write_reg(CP0_STATUS, wd);
        read_reg(CP0_STATUS, rd);
        check_val("Status", rd, status_model(32'h0040_0000, wd));
        @(negedge clk);
        hw_int = 6'(rand_bits(6));
        wd = rand_bits(32);
        ip_sw = wd[9:8];
        write_reg(CP0_CAUSE, wd);
        read_reg(CP0_CAUSE, rd);
        check_val("Cause", rd, cause_model(1'b0, 1'b0, hw_int, ip_sw, 5'd0));
        @(negedge clk);
        hw_int = '0;

        // timer
        read_reg(CP0_COUNT, c0);
        repeat (19) @(negedge clk);
        read_reg(CP0_COUNT, c1);
        check_val("Count", c1 - c0, 32'd10);
        write_reg(CP0_STATUS, 32'h0000_8000);
        read_reg(CP0_COUNT, c0);
        write_reg(CP0_COMPARE, c0 + 32'd6);
        wait_timer_irq(64);
        check_val("int_pending_o[7]", int_pending[7], 1'b1);
        write_reg(CP0_COMPARE, c0 + 32'h8000_0000);
        read_reg(CP0_CAUSE, rd);
        check_val("Cause.TI", rd[30], 1'b0);
        check_val("int_pending_o[7]", int_pending[7], 1'b0);

        // exception beats a software write to EPC in the same cycle
        write_reg(CP0_STATUS, 32'h0000_0001);
        read_reg(CP0_STATUS, rd);
        check_val("allow_int_o", allow_int, 1'b1);
        rec.bd = 1'(rand_bits(1));
        rec.code = 5'(rand_bits(5));
        rec.epc = rand_bits(32);
        rec.badvaddr = rand_bits(32);
        rec.badvaddr_we = 1'b1;
        @(negedge clk);
        exc_valid = 1'b1;
        exc_in = rec;
        cp0_we = 1'b1;
        cp0_waddr = CP0_EPC;
        cp0_wdata = ~rec.epc;
        #2;
        check_val("allow_int_o", allow_int, 1'b0);
        @(negedge clk);
        exc_valid = 1'b0;
        cp0_we = 1'b0;
        read_reg(CP0_EPC, rd);
        check_val("EPC", rd, rec.epc);
        check_val("epc_o", epc, rec.epc);
        read_reg(CP0_CAUSE, rd);
        check_val("Cause", rd, cause_model(rec.bd, 1'b0, 6'd0, ip_sw, rec.code));
        read_reg(CP0_BADVADDR, rd);
        check_val("BadVAddr", rd, rec.badvaddr);
        read_reg(CP0_ENTRYHI, rd);
        check_val("EntryHi.VPN2", rd[31:13], rec.badvaddr[31:13]);
        read_reg(CP0_STATUS, rd);
        check_val("Status.EXL", rd[1], 1'b1);
        check_val("allow_int_o", allow_int, 1'b0);
        pulse_strobe(S_ERET);
        read_reg(CP0_STATUS, rd);
        check_val("Status.EXL", rd[1], 1'b0);
        check_val("allow_int_o", allow_int, 1'b1);

        // fill the TLB with entry 1 global and odd entries in kseg2/3
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            m_vpn2[i] = {((i % 2) != 0 ? 3'b110 : 3'b001), 12'(rand_bits(12)), 4'(i)};
            m_asid[i] = 8'(rand_bits(8));
            m_g[i] = (i == 1);
            m_lo0[i] = {6'b0, 25'(rand_bits(25)), m_g[i]};
            m_lo1[i] = {6'b0, 25'(rand_bits(25)), m_g[i]};
            write_reg(CP0_INDEX, i);
            write_reg(CP0_ENTRYHI, {m_vpn2[i], 5'b0, m_asid[i]});
            write_reg(CP0_ENTRYLO0, m_lo0[i]);
            write_reg(CP0_ENTRYLO1, m_lo1[i]);
            pulse_strobe(S_TLBWI);
        end
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            write_reg(CP0_ENTRYHI, {m_vpn2[i], 5'b0, m_asid[i]});
            pulse_strobe(S_TLBP);
            read_reg(CP0_INDEX, rd);
            check_val("Index", rd, i);
        end
        write_reg(CP0_ENTRYHI, {m_vpn2[0] ^ 19'h10, 5'b0, m_asid[0]});
        pulse_strobe(S_TLBP);
        read_reg(CP0_INDEX, rd);
        check_val("Index.P", rd[31], 1'b1);
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            write_reg(CP0_INDEX, i);
            pulse_strobe(S_TLBR);
            read_reg(CP0_ENTRYHI, rd);
            check_val("EntryHi", rd, {m_vpn2[i], 5'b0, m_asid[i]});
            read_reg(CP0_ENTRYLO0, rd);
            check_val("EntryLo0", rd, m_lo0[i]);
            read_reg(CP0_ENTRYLO1, rd);
            check_val("EntryLo1", rd, m_lo1[i]);
        end

        // translation under a matching and a foreign ASID
        cur_asid_m = m_asid[0];
        write_reg(CP0_ENTRYHI, {24'b0, cur_asid_m});
        xlate_round(40);
        cur_asid_m = m_asid[0] ^ 8'h5a;
        write_reg(CP0_ENTRYHI, {24'b0, cur_asid_m});
        check_xlate({m_vpn2[1], 13'h0abc}, {m_vpn2[1], 13'h1abc}, 1'b1);
        xlate_round(40);
        write_reg(CP0_CONFIG, 32'd2);
        k0_uncached_m = 1'b1;
        xlate_round(20);
        write_reg(CP0_CONFIG, 32'd3);
        k0_uncached_m = 1'b0;

        // user mode and cache-off
        write_reg(CP0_STATUS, 32'h0000_0010);
        user_mode_m = 1'b1;
        check_xlate(32'h8000_1000, 32'hc000_2000, 1'b0);
        check_val("data_res_o.illegal", data_res.illegal, 1'b1);
        xlate_round(10);
        write_reg(CP0_STATUS, 32'h0000_0000);
        user_mode_m = 1'b0;
        write_reg(CP0_CACHEOFF, 32'd1);
        cache_off_m = 1'b1;
        check_xlate(32'h8000_0040, {m_vpn2[0], 13'h0040}, 1'b0);
        check_val("inst_res_o.uncached", inst_res.uncached, 1'b1);
        xlate_round(10);

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule
